//--- filelist.f
source/game_geom_pkg.sv
source/song_pkg.sv
source/lane_if.sv
source/key_decoder.sv
source/beat_timer.sv
source/song_sequencer.sv
source/note_field.sv
source/scoreboard.sv
source/rhythm_game_top.sv
+incdir+test
test/tb_rhythm_game.sv

//--- source/beat_timer.sv
/*
 * Beat timer: divides frame ticks into beat strobes
 * and keeps the index of the current beat
 */
`default_nettype none

module beat_timer #(
	parameter int FRAMES_PER_BEAT = 16
) (
	input  wire                      max10_clk1_50,
	input  wire                      arst_n,
	input  wire                      frame_tick,
	input  wire                      run,
	input  wire                      restart,
	output logic                     beat,
	output song_pkg::beat_idx_t      beat_index
);

	localparam int FRAME_W = (FRAMES_PER_BEAT > 1) ? $clog2(FRAMES_PER_BEAT) : 1;
	localparam logic [FRAME_W-1:0] LAST_FRAME = FRAME_W'(FRAMES_PER_BEAT - 1);

	logic [FRAME_W-1:0] frame_cnt;

	always_ff @(posedge max10_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			frame_cnt  <= '0;
			beat       <= 1'b0;
			beat_index <= '0;
		end else if (restart) begin
			frame_cnt  <= '0;
			beat       <= 1'b0;
			beat_index <= '0;
		end else begin
			beat <= 1'b0;
			if (beat)
				beat_index <= beat_index + 1'b1; // Advance once the beat is out
			if (run && frame_tick) begin
				if (frame_cnt == LAST_FRAME) begin
					frame_cnt <= '0;
					beat      <= 1'b1;
				end else begin
					frame_cnt <= frame_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/game_geom_pkg.sv
/*
 * Playfield geometry: lane count, note positions, fall speed,
 * hit window bounds and score counter widths
 */
`default_nettype none

package game_geom_pkg;

	// ==================================================
	// Lanes and positions
	// ==================================================
	localparam int NUM_LANES = 4;

	typedef logic [9:0] pos_t;          // Vertical pixel position
	typedef logic [NUM_LANES-1:0] lane_mask_t;

	localparam pos_t FALL_STEP = 10'd4; // Pixels per frame

	// ==================================================
	// Hit window
	// ==================================================
	localparam pos_t HIT_Y_MIN = 10'd400;
	localparam pos_t HIT_Y_MAX = 10'd440;

	// Score counters
	typedef logic [7:0] count_t;

endpackage

`default_nettype wire

//--- source/key_decoder.sv
/*
 * Keycode edge detector: start, stop and per-lane press strobes
 */
`default_nettype none

module key_decoder (
	input  wire                 max10_clk1_50,
	input  wire                 arst_n,
	input  wire song_pkg::key_t keycode,
	output logic                start,
	output logic                stop,
	lane_if.keys                lanes
);

	song_pkg::key_t key_q;
	logic changed;
	game_geom_pkg::lane_mask_t lane_match;

	assign changed = (keycode != key_q); // Held keys give no repeat

	assign lane_match = {
		keycode == song_pkg::KEY_LANE3,
		keycode == song_pkg::KEY_LANE2,
		keycode == song_pkg::KEY_LANE1,
		keycode == song_pkg::KEY_LANE0
	};

	always_ff @(posedge max10_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			key_q       <= '0;
			start       <= 1'b0;
			stop        <= 1'b0;
			lanes.press <= '0;
		end else begin
			key_q       <= keycode;
			start       <= changed && (keycode == song_pkg::KEY_START);
			stop        <= changed && (keycode == song_pkg::KEY_STOP);
			lanes.press <= changed ? lane_match : '0;
		end
	end

endmodule

`default_nettype wire

//--- source/lane_if.sv
/*
 * Per-lane event bundle between sequencer, key decoder,
 * note field and scoreboard
 */
`default_nettype none

interface lane_if;

	game_geom_pkg::lane_mask_t trigger; // Spawn a note
	game_geom_pkg::lane_mask_t press;   // Key went down
	game_geom_pkg::lane_mask_t hit;
	game_geom_pkg::lane_mask_t miss;
	logic clear;                        // Drop all notes
	logic busy;                         // Any note still falling

	modport seq   (output trigger, output clear, input busy);
	modport keys  (output press);
	modport field (input trigger, input press, input clear,
	               output hit, output miss, output busy);
	modport score (input hit, input miss, input clear);

endinterface

`default_nettype wire

//--- source/note_field.sv
/*
 * Note slots of all lanes: spawning, falling per frame,
 * hit window search on key press and miss detection
 */
`default_nettype none

module note_field #(
	parameter int NOTE_SLOTS = 8
) (
	input  wire  max10_clk1_50,
	input  wire  arst_n,
	input  wire  frame_tick,
	lane_if.field lanes
);

	localparam int SLOT_W = (NOTE_SLOTS > 1) ? $clog2(NOTE_SLOTS) : 1;
	localparam int NL = game_geom_pkg::NUM_LANES;

	typedef logic [SLOT_W-1:0] slot_idx_t;

	logic [NOTE_SLOTS-1:0] active [NL];
	game_geom_pkg::pos_t pos [NL][NOTE_SLOTS];
	logic hit_r [NL];
	logic miss_r [NL];
	game_geom_pkg::lane_mask_t hit_mask, miss_mask, busy_mask;

	// ==================================================
	// One slot bank per lane
	// ==================================================
	for (genvar l = 0; l < NL; l++) begin : g_lane
		slot_idx_t free_idx, win_idx;
		logic free_ok, win_ok;
		logic [NOTE_SLOTS-1:0] take_hit, take_fall, take_spawn;
		game_geom_pkg::pos_t pos_next [NOTE_SLOTS];

		// Lowest free slot and lowest slot inside the window
		always_comb begin
			free_idx = '0;
			free_ok  = 1'b0;
			win_idx  = '0;
			win_ok   = 1'b0;
			for (int s = NOTE_SLOTS - 1; s >= 0; s--) begin
				if (!active[l][s]) begin
					free_idx = slot_idx_t'(s);
					free_ok  = 1'b1;
				end
				if (active[l][s] && pos[l][s] >= game_geom_pkg::HIT_Y_MIN &&
				    pos[l][s] <= game_geom_pkg::HIT_Y_MAX) begin
					win_idx = slot_idx_t'(s);
					win_ok  = 1'b1;
				end
			end
		end

		always_comb begin
			for (int s = 0; s < NOTE_SLOTS; s++) begin
				pos_next[s]   = pos[l][s] + game_geom_pkg::FALL_STEP;
				take_hit[s]   = lanes.press[l] && win_ok && (win_idx == slot_idx_t'(s));
				// A note taken by a press this cycle is not also a miss
				take_fall[s]  = frame_tick && active[l][s] && !take_hit[s] &&
				                (pos_next[s] > game_geom_pkg::HIT_Y_MAX);
				take_spawn[s] = lanes.trigger[l] && free_ok && (free_idx == slot_idx_t'(s));
			end
		end

		always_ff @(posedge max10_clk1_50 or negedge arst_n) begin
			if (!arst_n) begin
				active[l] <= '0;
				hit_r[l]  <= 1'b0;
				miss_r[l] <= 1'b0;
			end else if (lanes.clear) begin
				active[l] <= '0;
				hit_r[l]  <= 1'b0;
				miss_r[l] <= 1'b0;
			end else begin
				active[l] <= (active[l] & ~take_hit & ~take_fall) | take_spawn;
				hit_r[l]  <= |take_hit;
				miss_r[l] <= |take_fall;
			end
		end

		always_ff @(posedge max10_clk1_50) begin
			for (int s = 0; s < NOTE_SLOTS; s++) begin
				if (take_spawn[s])
					pos[l][s] <= '0;             // Top of the lane
				else if (frame_tick && active[l][s])
					pos[l][s] <= pos_next[s];
			end
		end
	end

	// Gather lane results
	always_comb begin
		for (int l = 0; l < NL; l++) begin
			hit_mask[l]  = hit_r[l];
			miss_mask[l] = miss_r[l];
			busy_mask[l] = |active[l];
		end
	end

	assign lanes.hit  = hit_mask;
	assign lanes.miss = miss_mask;
	assign lanes.busy = |busy_mask;

endmodule

`default_nettype wire

//--- source/rhythm_game_top.sv
/*
 * Rhythm game core: key decoder, beat timer, sequencer,
 * note field and scoreboard around one lane bus
 */
`default_nettype none

module rhythm_game_top #(
	parameter int FRAMES_PER_BEAT = 16,
	parameter int NOTE_SLOTS      = 8
) (
	input  wire                         max10_clk1_50,
	input  wire                         arst_n,
	input  wire                         frame_tick,    // Vertical sync pulse
	input  wire song_pkg::key_t         keycode,
	output song_pkg::game_state_t       state,
	output game_geom_pkg::lane_mask_t   lane_hit,
	output game_geom_pkg::lane_mask_t   lane_miss,
	output game_geom_pkg::count_t       hit_count,
	output game_geom_pkg::count_t       miss_count,
	output game_geom_pkg::count_t       combo
);

	logic start, stop, run, restart, beat;
	song_pkg::beat_idx_t beat_index;

	lane_if lanes ();

	// ==================================================
	// Control path
	// ==================================================
	key_decoder u_keys (.max10_clk1_50, .arst_n, .keycode, .start, .stop,
		.lanes(lanes.keys));

	beat_timer #(.FRAMES_PER_BEAT(FRAMES_PER_BEAT)) u_timer (.max10_clk1_50, .arst_n,
		.frame_tick, .run, .restart, .beat, .beat_index);

	song_sequencer u_seq (.max10_clk1_50, .arst_n, .start, .stop, .beat, .beat_index,
		.run, .restart, .state, .lanes(lanes.seq));

	// ==================================================
	// Notes and score
	// ==================================================
	note_field #(.NOTE_SLOTS(NOTE_SLOTS)) u_field (.max10_clk1_50, .arst_n, .frame_tick,
		.lanes(lanes.field));

	scoreboard u_score (.max10_clk1_50, .arst_n, .lanes(lanes.score), .hit_count,
		.miss_count, .combo);

	assign lane_hit  = lanes.hit;
	assign lane_miss = lanes.miss;

endmodule

`default_nettype wire

//--- source/scoreboard.sv
/*
 * Saturating hit, miss and combo counters
 */
`default_nettype none

module scoreboard (
	input  wire                     max10_clk1_50,
	input  wire                     arst_n,
	lane_if.score                   lanes,
	output game_geom_pkg::count_t   hit_count,
	output game_geom_pkg::count_t   miss_count,
	output game_geom_pkg::count_t   combo
);

	logic clear_q;
	logic [2:0] hit_n, miss_n;

	function automatic game_geom_pkg::count_t sat_add(game_geom_pkg::count_t a, logic [2:0] b);
		logic [$bits(game_geom_pkg::count_t):0] sum;
		sum = {1'b0, a} + b;
		return sum[$bits(game_geom_pkg::count_t)] ? '1 : sum[$bits(game_geom_pkg::count_t)-1:0];
	endfunction

	assign hit_n  = 3'($countones(lanes.hit));  // Lanes hit this cycle
	assign miss_n = 3'($countones(lanes.miss));

	always_ff @(posedge max10_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			clear_q    <= 1'b0;
			hit_count  <= '0;
			miss_count <= '0;
			combo      <= '0;
		end else begin
			clear_q <= lanes.clear;
			if (lanes.clear && clear_q) begin // Two-cycle clear marks a new game
				hit_count  <= '0;
				miss_count <= '0;
				combo      <= '0;
			end else begin
				hit_count  <= sat_add(hit_count, hit_n);
				miss_count <= sat_add(miss_count, miss_n);
				combo      <= (miss_n != 3'd0) ? '0 : sat_add(combo, hit_n);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/song_pkg.sv
/*
 * Keyboard codes, game state encoding, song length
 * and the fixed beat pattern of the song
 */
`default_nettype none

package song_pkg;

	typedef logic [7:0] key_t;

	// USB HID usage codes
	localparam key_t KEY_START = 8'h2C; // Space
	localparam key_t KEY_STOP  = 8'h29; // Escape
	localparam key_t KEY_LANE0 = 8'h07; // d
	localparam key_t KEY_LANE1 = 8'h09; // f
	localparam key_t KEY_LANE2 = 8'h0D; // j
	localparam key_t KEY_LANE3 = 8'h0E; // k

	typedef enum logic [1:0] {IDLE, PLAYING, DRAIN, DONE} game_state_t;

	localparam int SONG_LEN = 16;
	typedef logic [3:0] beat_idx_t;

	// ==================================================
	// Song pattern, one lane mask per beat
	// ==================================================
	function automatic game_geom_pkg::lane_mask_t beat_lanes(beat_idx_t idx);
		case (idx)
			4'd0:    return 4'b0001;
			4'd1:    return 4'b0010;
			4'd2:    return 4'b0100;
			4'd3:    return 4'b1000;
			4'd4:    return 4'b0000; // Rest
			4'd5:    return 4'b0011;
			4'd6:    return 4'b0100;
			4'd7:    return 4'b1000;
			4'd8:    return 4'b0001;
			4'd9:    return 4'b0000; // Rest
			4'd10:   return 4'b1100;
			4'd11:   return 4'b0010;
			4'd12:   return 4'b0001;
			4'd13:   return 4'b1001;
			4'd14:   return 4'b0100;
			default: return 4'b0010;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- source/song_sequencer.sv
/*
 * Game FSM: start and stop handling, pattern lookup per beat,
 * end of song and drain detection
 */
`default_nettype none

module song_sequencer (
	input  wire                         max10_clk1_50,
	input  wire                         arst_n,
	input  wire                         start,
	input  wire                         stop,
	input  wire                         beat,
	input  wire song_pkg::beat_idx_t    beat_index,
	output logic                        run,
	output logic                        restart,
	output song_pkg::game_state_t       state,
	lane_if.seq                         lanes
);

	localparam song_pkg::beat_idx_t LAST_BEAT = song_pkg::beat_idx_t'(song_pkg::SONG_LEN - 1);

	logic go;

	// Start only from a finished or idle game
	assign go = start && (state == song_pkg::IDLE || state == song_pkg::DONE);

	always_ff @(posedge max10_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			state         <= song_pkg::IDLE;
			run           <= 1'b0;
			restart       <= 1'b0;
			lanes.trigger <= '0;
			lanes.clear   <= 1'b0;
		end else begin
			restart       <= 1'b0;
			lanes.trigger <= '0;
			// A new game holds clear for a second cycle so the score resets too
			lanes.clear   <= restart;

			if (stop) begin
				state       <= song_pkg::IDLE;
				run         <= 1'b0;
				lanes.clear <= 1'b1;
			end else if (go) begin
				state       <= song_pkg::PLAYING;
				run         <= 1'b1;
				restart     <= 1'b1;
				lanes.clear <= 1'b1;
			end else begin
				case (state)
					song_pkg::PLAYING: begin
						if (beat) begin
							lanes.trigger <= song_pkg::beat_lanes(beat_index);
							if (beat_index == LAST_BEAT) begin
								state <= song_pkg::DRAIN;
								run   <= 1'b0;
							end
						end
					end
					song_pkg::DRAIN: begin
						// Last trigger is not visible in busy yet
						if (!lanes.busy && lanes.trigger == '0)
							state <= song_pkg::DONE;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- test/tb_checks.svh
/*
 * Testbench helpers: LFSR lane picker, typed compare tasks
 * and the check and error counters
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int checks = 0;
int errors = 0;
logic [31:0] lfsr_state = 32'h7db75f3f;

// ==================================================
// Random numbers
// ==================================================
function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // x^32+x^22+x^2+x+1
endfunction

// One step per bit taken
function automatic int take_bits(int n);
	int v;
	v = 0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = (v << 1) | lfsr_state[0];
	end
	return v;
endfunction

// ==================================================
// Compare tasks
// ==================================================
task automatic check_state(song_pkg::game_state_t got, song_pkg::game_state_t exp, string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %0t: %s: state %s, expected %s", $time, what, got.name(), exp.name());
	end
endtask

task automatic check_mask(game_geom_pkg::lane_mask_t got, game_geom_pkg::lane_mask_t exp,
		string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %0t: %s: mask %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_count(game_geom_pkg::count_t got, game_geom_pkg::count_t exp, string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %0t: %s: count %0d, expected %0d", $time, what, got, exp);
	end
endtask

`endif

//--- test/tb_rhythm_game.sv
/*
 * Directed testbench for the rhythm game core: frame driver,
 * key presses and whole-song scoring runs
 */
`default_nettype none

module tb_rhythm_game;

	localparam int FPB = 16;
	localparam int SONG_TICKS = song_pkg::SONG_LEN * FPB + 120; // Past the last miss

	logic max10_clk1_50 = 1'b0;
	logic arst_n, frame_tick, quiet;
	song_pkg::key_t keycode;
	song_pkg::game_state_t state;
	game_geom_pkg::lane_mask_t lane_hit, lane_miss, pressed_lanes;
	game_geom_pkg::count_t hit_count, miss_count, combo;
	int ticks, presses, hits_seen, misses_seen;

	`include "tb_checks.svh"

	rhythm_game_top #(.FRAMES_PER_BEAT(FPB), .NOTE_SLOTS(8)) dut_i (.max10_clk1_50, .arst_n,
		.frame_tick, .keycode, .state, .lane_hit, .lane_miss, .hit_count, .miss_count, .combo);

	always #4 max10_clk1_50 = ~max10_clk1_50;

	// Pulse monitor on the idle clock edge
	always @(negedge max10_clk1_50) begin
		if (arst_n === 1'b1) begin
			hits_seen   += $countones(lane_hit);
			misses_seen += $countones(lane_miss);
			if (lane_miss != '0)
				check_mask(lane_miss, misses_at_tick(ticks + 1, pressed_lanes),
					"miss pulse lanes");
			if (quiet)
				check_mask(lane_hit | lane_miss, '0, "hit or miss pulse");
		end
	end

	// ==================================================
	// Expected values from the song pattern
	// ==================================================
	function automatic song_pkg::key_t lane_key(int l);
		case (l)
			0:       return song_pkg::KEY_LANE0;
			1:       return song_pkg::KEY_LANE1;
			2:       return song_pkg::KEY_LANE2;
			default: return song_pkg::KEY_LANE3;
		endcase
	endfunction

	// Key after tick n with notes of one beat on successive ticks
	function automatic song_pkg::key_t key_for_tick(int n, game_geom_pkg::lane_mask_t lanes);
		int k;
		game_geom_pkg::lane_mask_t m;
		for (int b = 0; b < song_pkg::SONG_LEN; b++) begin
			m = song_pkg::beat_lanes(song_pkg::beat_idx_t'(b)) & lanes;
			k = 0;
			for (int l = 0; l < game_geom_pkg::NUM_LANES; l++) begin
				if (m[l]) begin
					if (n == (b + 1) * FPB + 105 + k)
						return lane_key(l);
					k++;
				end
			end
		end
		return 8'h00;
	endfunction

	// Unpressed notes that leave the window on tick n
	function automatic game_geom_pkg::lane_mask_t misses_at_tick(int n,
			game_geom_pkg::lane_mask_t pressed);
		game_geom_pkg::lane_mask_t m;
		m = '0;
		for (int b = 0; b < song_pkg::SONG_LEN; b++)
			if (n == (b + 1) * FPB + 111)
				m |= song_pkg::beat_lanes(song_pkg::beat_idx_t'(b)) & ~pressed;
		return m;
	endfunction

	function automatic int notes_in(game_geom_pkg::lane_mask_t lanes);
		int n;
		n = 0;
		for (int b = 0; b < song_pkg::SONG_LEN; b++)
			n += $countones(song_pkg::beat_lanes(song_pkg::beat_idx_t'(b)) & lanes);
		return n;
	endfunction

	// Hits whose window tick comes after the last miss
	function automatic int combo_after_last_miss(game_geom_pkg::lane_mask_t pressed);
		int last_miss, c;
		game_geom_pkg::lane_mask_t m;
		last_miss = -1;
		c = 0;
		for (int b = 0; b < song_pkg::SONG_LEN; b++) begin
			m = song_pkg::beat_lanes(song_pkg::beat_idx_t'(b));
			if ((m & ~pressed) != '0)
				last_miss = (b + 1) * FPB + 111;
		end
		for (int b = 0; b < song_pkg::SONG_LEN; b++) begin
			m = song_pkg::beat_lanes(song_pkg::beat_idx_t'(b)) & pressed;
			if ((b + 1) * FPB + 105 > last_miss)
				c += $countones(m);
		end
		return c;
	endfunction

	// ==================================================
	// Drivers and waits
	// ==================================================
	task automatic next_cycle();
		@(posedge max10_clk1_50);
		#1;
	endtask

	task automatic drive_frame(song_pkg::key_t key);
		frame_tick = 1'b1;
		next_cycle();
		frame_tick = 1'b0;
		keycode    = key; // Held until the next frame
		repeat (5) next_cycle();
		ticks++;
	endtask

	task automatic play_ticks(game_geom_pkg::lane_mask_t lanes, int last);
		song_pkg::key_t key;
		pressed_lanes = lanes;
		while (ticks < last) begin
			key = key_for_tick(ticks + 1, lanes);
			if (key != 8'h00)
				presses++;
			drive_frame(key);
		end
	endtask

	task automatic timeout_abort(string what);
		$display("Timeout while waiting for state %s", what);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic wait_for_state(song_pkg::game_state_t exp, int limit, logic by_frame);
		int n;
		n = 0;
		while (state != exp && n < limit) begin
			if (by_frame)
				drive_frame(8'h00);
			else
				next_cycle();
			n++;
		end
		if (state != exp)
			timeout_abort(exp.name());
	endtask

	task automatic expect_counts(int h, int m, int c, string what);
		check_count(hit_count, game_geom_pkg::count_t'(h), {what, ", hit_count"});
		check_count(miss_count, game_geom_pkg::count_t'(m), {what, ", miss_count"});
		check_count(combo, game_geom_pkg::count_t'(c), {what, ", combo"});
	endtask

	task automatic start_game();
		quiet   = 1'b0;
		keycode = song_pkg::KEY_START;
		wait_for_state(song_pkg::PLAYING, 8, 1'b0);
		repeat (3) next_cycle(); // Timer restart and score clear
		ticks       = 0;
		presses     = 0;
		hits_seen   = 0;
		misses_seen = 0;
		expect_counts(0, 0, 0, "new game");
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic idle_after_reset();
		check_state(state, song_pkg::IDLE, "state after reset");
		expect_counts(0, 0, 0, "after reset");
		quiet = 1'b1;
		repeat (20) drive_frame(8'h00);
		quiet = 1'b0;
	endtask

	task automatic song_without_presses();
		start_game();
		play_ticks('0, SONG_TICKS);
		wait_for_state(song_pkg::DONE, 40, 1'b1);
		check_count(game_geom_pkg::count_t'(misses_seen), game_geom_pkg::count_t'(notes_in('1)),
			"miss pulses");
		expect_counts(0, notes_in('1), 0, "song without presses");
	endtask

	task automatic song_all_pressed();
		start_game();
		play_ticks('1, SONG_TICKS);
		wait_for_state(song_pkg::DONE, 40, 1'b1);
		check_count(game_geom_pkg::count_t'(hits_seen), game_geom_pkg::count_t'(notes_in('1)),
			"hit pulses");
		expect_counts(notes_in('1), 0, notes_in('1), "song fully pressed");
	endtask

	task automatic presses_without_notes();
		quiet = 1'b1;
		repeat (8) begin
			drive_frame(lane_key(take_bits(2)));
			drive_frame(8'h00);
		end
		quiet = 1'b0;
		expect_counts(notes_in('1), 0, notes_in('1), "presses with no note");
	endtask

	task automatic song_lane0_only();
		start_game();
		play_ticks(4'b0001, SONG_TICKS);
		wait_for_state(song_pkg::DONE, 40, 1'b1);
		expect_counts(notes_in(4'b0001), notes_in(4'b1110), combo_after_last_miss(4'b0001),
			"lane 0 only");
	endtask

	task automatic stop_and_replay();
		start_game();
		play_ticks('1, 200); // Between two presses
		keycode = song_pkg::KEY_STOP;
		wait_for_state(song_pkg::IDLE, 8, 1'b0);
		quiet = 1'b1;
		repeat (150) drive_frame(8'h00);
		quiet = 1'b0;
		check_state(state, song_pkg::IDLE, "after stop");
		expect_counts(presses, 0, presses, "after stop");
		start_game();
		play_ticks('1, SONG_TICKS);
		wait_for_state(song_pkg::DONE, 40, 1'b1);
		expect_counts(notes_in('1), 0, notes_in('1), "replay");
	endtask

	initial begin
		arst_n        = 1'b0;
		frame_tick    = 1'b0;
		keycode       = 8'h00;
		quiet         = 1'b0;
		ticks         = 0;
		presses       = 0;
		hits_seen     = 0;
		misses_seen   = 0;
		pressed_lanes = '0;
		repeat (3) @(posedge max10_clk1_50);
		#1;
		arst_n = 1'b1;

		idle_after_reset();
		song_without_presses();
		song_all_pressed();
		presses_without_notes();
		song_lane0_only();
		stop_and_replay();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
